// ==== emu_config_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module emu_config_regs (
    input  wire logic                     clk24MHz,
    input  wire logic                     act,
    input  wire eprom_emu_pkg::usb_byte_t  ft240x_din,
    input  wire logic                     mode_we,
    input  wire logic                     exfil_hi_we,
    input  wire logic                     exfil_lo_we,
    output eprom_emu_pkg::emu_mode_t      mode,
    output logic                          exfil_en,
    output eprom_emu_pkg::exfil_page_t    exfil_page
);

    ////////////////////////////////////////////////////////////////////////////
    // Mode and exfiltration enable

    // Byte layout X e m m, both mode bits kept as sent
    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            mode     <= eprom_emu_pkg::mode_load;
            exfil_en <= 1'b0;
        end else if (mode_we) begin
            mode     <= eprom_emu_pkg::emu_mode_t'(ft240x_din[1:0]);
            exfil_en <= ft240x_din[2];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Exfiltration page

    // Upper two bits arrive with the command byte
    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            exfil_page[9:8] <= '0;
        end else if (exfil_hi_we) begin
            exfil_page[9:8] <= ft240x_din[1:0];
        end
    end

    // Bits 15:8 of the address, from the following byte
    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            exfil_page[7:0] <= '0;
        end else if (exfil_lo_we) begin
            exfil_page[7:0] <= ft240x_din;
        end
    end

endmodule

`default_nettype wire

// ==== eprom_emu_pkg.sv ====
`default_nettype none

package eprom_emu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int usb_byte_w   = 8;
    localparam int sram_addr_w  = 18;
    localparam int sram_word_w  = 16;
    localparam int exfil_page_w = 10;
    localparam int word_count_w = 4;

    // One byte on the FT240X FIFO bus
    typedef logic [usb_byte_w-1:0]   usb_byte_t;
    // Target address, also the SRAM address
    typedef logic [sram_addr_w-1:0]  sram_addr_t;
    typedef logic [sram_word_w-1:0]  sram_word_t;
    // Address bits 17:8 of the watched page
    typedef logic [exfil_page_w-1:0] exfil_page_t;
    typedef logic [word_count_w-1:0] word_count_t;

    // Both mode bits are stored as sent, so the two park codes exist
    typedef enum logic [1:0] {
        mode_load   = 2'd0,
        mode_run    = 2'd1,
        mode_park_2 = 2'd2,
        mode_park_3 = 2'd3
    } emu_mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Host command codes

    localparam usb_byte_t    cmd_nop             = 8'h00;
    localparam usb_byte_t    cmd_reset_addr      = 8'h01;
    // 0001_Xemm: e = exfiltration enable, mm = mode
    localparam logic [3:0]   cmd_set_mode_prefix = 4'h1;
    // 0010_nnnn: write nnnn words, 0 means 16
    localparam logic [3:0]   cmd_write_prefix    = 4'h2;
    // 0100_XXEE: EE = page bits 17:16, next byte gives 15:8
    localparam logic [3:0]   cmd_exfil_prefix    = 4'h4;

endpackage

`default_nettype wire

// ==== eprom_emu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module eprom_emu_top (
    input  wire logic                     clk24MHz,
    input  wire logic                     act,
    // Target side, program strobes kept for pin compatibility
    input  wire logic                     tgt_npgmh,
    input  wire logic                     tgt_npgml,
    input  wire eprom_emu_pkg::sram_addr_t addr_bus,
    input  wire logic                     tgt_nce,
    input  wire logic                     tgt_noel,
    input  wire logic                     tgt_noeh,
    output logic                          target_dbusbuf_en,
    // FT240X FIFO, data bus split into in, out and enable
    input  wire eprom_emu_pkg::usb_byte_t  ft240x_din,
    output eprom_emu_pkg::usb_byte_t      ft240x_dout,
    output logic                          ft240x_doe,
    output logic                          ft240x_nrd,
    output logic                          ft240x_nwr,
    input  wire logic                     ft240x_txe,
    input  wire logic                     ft240x_rxf,
    // SRAM
    output eprom_emu_pkg::sram_addr_t     sram_addr,
    output eprom_emu_pkg::sram_word_t     sram_data_out,
    output logic                          sram_data_oe,
    output logic                          sram_nwe,
    output logic                          sram_noe
);

    // Sequencer strobes
    logic mode_we;
    logic exfil_hi_we;
    logic exfil_lo_we;
    logic addr_clr;
    logic latch_hi;
    logic latch_lo;
    logic write_pulse;
    logic addr_inc;

    // Configuration
    eprom_emu_pkg::emu_mode_t   mode;
    logic                       exfil_en;
    eprom_emu_pkg::exfil_page_t exfil_page;

    ft240x_cmd_fsm u_cmd_fsm (
        .clk24MHz    (clk24MHz),
        .act         (act),
        .ft240x_rxf  (ft240x_rxf),
        .ft240x_din  (ft240x_din),
        .ft240x_nrd  (ft240x_nrd),
        .mode_we     (mode_we),
        .exfil_hi_we (exfil_hi_we),
        .exfil_lo_we (exfil_lo_we),
        .addr_clr    (addr_clr),
        .latch_hi    (latch_hi),
        .latch_lo    (latch_lo),
        .write_pulse (write_pulse),
        .addr_inc    (addr_inc)
    );

    emu_config_regs u_config_regs (
        .clk24MHz    (clk24MHz),
        .act         (act),
        .ft240x_din  (ft240x_din),
        .mode_we     (mode_we),
        .exfil_hi_we (exfil_hi_we),
        .exfil_lo_we (exfil_lo_we),
        .mode        (mode),
        .exfil_en    (exfil_en),
        .exfil_page  (exfil_page)
    );

    sram_load_port u_load_port (
        .clk24MHz      (clk24MHz),
        .act           (act),
        .mode          (mode),
        .addr_bus      (addr_bus),
        .ft240x_din    (ft240x_din),
        .addr_clr      (addr_clr),
        .latch_hi      (latch_hi),
        .latch_lo      (latch_lo),
        .write_pulse   (write_pulse),
        .addr_inc      (addr_inc),
        .sram_addr     (sram_addr),
        .sram_data_out (sram_data_out),
        .sram_data_oe  (sram_data_oe),
        .sram_nwe      (sram_nwe)
    );

    target_bus_router u_bus_router (
        .clk24MHz          (clk24MHz),
        .act               (act),
        .mode              (mode),
        .exfil_en          (exfil_en),
        .exfil_page        (exfil_page),
        .addr_bus          (addr_bus),
        .tgt_nce           (tgt_nce),
        .tgt_noel          (tgt_noel),
        .tgt_noeh          (tgt_noeh),
        .ft240x_txe        (ft240x_txe),
        .target_dbusbuf_en (target_dbusbuf_en),
        .sram_noe          (sram_noe),
        .ft240x_nwr        (ft240x_nwr),
        .ft240x_dout       (ft240x_dout),
        .ft240x_doe        (ft240x_doe)
    );

endmodule

`default_nettype wire

// ==== ft240x_cmd_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module ft240x_cmd_fsm (
    input  wire logic                    clk24MHz,
    input  wire logic                    act,
    input  wire logic                    ft240x_rxf,
    input  wire eprom_emu_pkg::usb_byte_t ft240x_din,
    output logic                         ft240x_nrd,
    output logic                         mode_we,
    output logic                         exfil_hi_we,
    output logic                         exfil_lo_we,
    output logic                         addr_clr,
    output logic                         latch_hi,
    output logic                         latch_lo,
    output logic                         write_pulse,
    output logic                         addr_inc
);

    typedef enum logic [3:0] {
        st_precharge,
        st_wait,
        st_pre_read,
        st_decode,
        st_wr_wait_hi,
        st_wr_hi_req,
        st_wr_hi_latch,
        st_wr_wait_lo,
        st_wr_lo_req,
        st_wr_lo_latch,
        st_wr_strobe,
        st_wr_release,
        st_wr_inc,
        st_ex_wait,
        st_ex_pre_read,
        st_ex_latch
    } fsm_state_t;

    fsm_state_t                 state;
    fsm_state_t                 next_state;
    eprom_emu_pkg::word_count_t count;
    logic                       count_load;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer registers

    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            state <= st_precharge;
            count <= '0;
        end else begin
            state <= next_state;
            if (count_load) begin
                count <= ft240x_din[3:0];
            end else if (state == st_wr_hi_req) begin
                // Zero wraps to 15, so WRITE 0 moves 16 words
                count <= count - eprom_emu_pkg::word_count_t'(1);
            end
        end
    end

    // RD# low over request and sample cycles, first one covers data-valid delay
    assign ft240x_nrd = !((state == st_pre_read)    || (state == st_decode)      ||
                          (state == st_wr_hi_req)   || (state == st_wr_hi_latch) ||
                          (state == st_wr_lo_req)   || (state == st_wr_lo_latch) ||
                          (state == st_ex_pre_read) || (state == st_ex_latch));

    assign latch_hi    = (state == st_wr_hi_latch);
    assign latch_lo    = (state == st_wr_lo_latch);
    assign write_pulse = (state == st_wr_strobe);
    assign addr_inc    = (state == st_wr_inc);
    assign exfil_lo_we = (state == st_ex_latch);

    ////////////////////////////////////////////////////////////////////////////
    // Next state and command decode

    always_comb begin
        next_state  = state;
        mode_we     = 1'b0;
        exfil_hi_we = 1'b0;
        addr_clr    = 1'b0;
        count_load  = 1'b0;
        case (state)
            // Precharge so a late RXF rise is not taken as a byte
            st_precharge:   next_state = st_wait;
            st_wait:        next_state = ft240x_rxf ? st_wait : st_pre_read;
            st_pre_read:    next_state = st_decode;
            st_decode: begin
                next_state = st_precharge;
                if (ft240x_din == eprom_emu_pkg::cmd_nop) begin
                    next_state = st_precharge;
                end else if (ft240x_din == eprom_emu_pkg::cmd_reset_addr) begin
                    addr_clr = 1'b1;
                end else if (ft240x_din[7:4] == eprom_emu_pkg::cmd_set_mode_prefix) begin
                    mode_we = 1'b1;
                end else if (ft240x_din[7:4] == eprom_emu_pkg::cmd_write_prefix) begin
                    count_load = 1'b1;
                    next_state = st_wr_wait_hi;
                end else if (ft240x_din[7:4] == eprom_emu_pkg::cmd_exfil_prefix) begin
                    // Page bits 17:16 come with the command itself
                    exfil_hi_we = 1'b1;
                    next_state  = st_ex_wait;
                end
                // Anything else is an undefined code, treated as NOP
            end
            // Word transfer, high byte first
            st_wr_wait_hi:  next_state = ft240x_rxf ? st_wr_wait_hi : st_wr_hi_req;
            st_wr_hi_req:   next_state = st_wr_hi_latch;
            st_wr_hi_latch: next_state = st_wr_wait_lo;
            st_wr_wait_lo:  next_state = ft240x_rxf ? st_wr_wait_lo : st_wr_lo_req;
            st_wr_lo_req:   next_state = st_wr_lo_latch;
            st_wr_lo_latch: next_state = st_wr_strobe;
            // WE# goes low one cycle later, in the release state
            st_wr_strobe:   next_state = st_wr_release;
            st_wr_release:  next_state = st_wr_inc;
            st_wr_inc:      next_state = (count != '0) ? st_wr_wait_hi : st_precharge;
            // Second byte of the page command
            st_ex_wait:     next_state = ft240x_rxf ? st_ex_wait : st_ex_pre_read;
            st_ex_pre_read: next_state = st_ex_latch;
            st_ex_latch:    next_state = st_precharge;
            default:        next_state = st_precharge;
        endcase
    end

    // Latch and write strobes belong to distinct steps of a word
    a_word_strobes_onehot : assert property (@(posedge clk24MHz) disable iff (act)
        $onehot0({latch_hi, latch_lo, write_pulse}));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
    --top-module tb_eprom_emu -Mdir "$build_dir" -o tb_eprom_emu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_eprom_emu" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failures found" "$log_file"; then
    exit 1
fi
exit 0

// ==== sim.f ====
eprom_emu_pkg.sv
ft240x_cmd_fsm.sv
emu_config_regs.sv
sram_load_port.sv
target_bus_router.sv
eprom_emu_top.sv
tb_clk_gen.sv
tb_eprom_emu.sv

// ==== sram_load_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_load_port (
    input  wire logic                     clk24MHz,
    input  wire logic                     act,
    input  wire eprom_emu_pkg::emu_mode_t  mode,
    input  wire eprom_emu_pkg::sram_addr_t addr_bus,
    input  wire eprom_emu_pkg::usb_byte_t  ft240x_din,
    input  wire logic                     addr_clr,
    input  wire logic                     latch_hi,
    input  wire logic                     latch_lo,
    input  wire logic                     write_pulse,
    input  wire logic                     addr_inc,
    output eprom_emu_pkg::sram_addr_t     sram_addr,
    output eprom_emu_pkg::sram_word_t     sram_data_out,
    output logic                          sram_data_oe,
    output logic                          sram_nwe
);

    eprom_emu_pkg::sram_addr_t addr_cnt;
    eprom_emu_pkg::sram_word_t word_latch;
    logic                      load_mode;

    assign load_mode = (mode == eprom_emu_pkg::mode_load);

    // Load address counter, cleared by command, stepped after each word
    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            addr_cnt <= '0;
        end else if (addr_clr) begin
            addr_cnt <= '0;
        end else if (addr_inc) begin
            addr_cnt <= addr_cnt + eprom_emu_pkg::sram_addr_t'(1);
        end
    end

    // Word assembly, high byte arrives first
    always_ff @(posedge clk24MHz) begin
        if (latch_hi) begin
            word_latch[15:8] <= ft240x_din;
        end
        if (latch_lo) begin
            word_latch[7:0] <= ft240x_din;
        end
    end

    // WE# low for the cycle after the pulse, never outside LOAD
    always_ff @(posedge clk24MHz or posedge act) begin
        if (act) begin
            sram_nwe <= 1'b1;
        end else begin
            sram_nwe <= !(write_pulse && load_mode);
        end
    end

    // Counter owns the SRAM in LOAD, the target owns it otherwise
    assign sram_addr     = load_mode ? addr_cnt : addr_bus;
    assign sram_data_out = word_latch;
    assign sram_data_oe  = load_mode;

    a_nwe_load_only : assert property (@(posedge clk24MHz) disable iff (act)
        !sram_nwe |-> (mode == eprom_emu_pkg::mode_load));

endmodule

`default_nettype wire

// ==== target_bus_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module target_bus_router (
    input  wire logic                      clk24MHz,
    input  wire logic                      act,
    input  wire eprom_emu_pkg::emu_mode_t   mode,
    input  wire logic                      exfil_en,
    input  wire eprom_emu_pkg::exfil_page_t exfil_page,
    input  wire eprom_emu_pkg::sram_addr_t  addr_bus,
    input  wire logic                      tgt_nce,
    input  wire logic                      tgt_noel,
    input  wire logic                      tgt_noeh,
    input  wire logic                      ft240x_txe,
    output logic                           target_dbusbuf_en,
    output logic                           sram_noe,
    output logic                           ft240x_nwr,
    output eprom_emu_pkg::usb_byte_t       ft240x_dout,
    output logic                           ft240x_doe
);

    logic run_mode;
    logic page_hit;

    assign run_mode = (mode == eprom_emu_pkg::mode_run);
    // Target access falls inside the watched 256-word page
    assign page_hit = run_mode && (addr_bus[17:8] == exfil_page);

    // Buffer opens only for a target read cycle in RUN
    assign target_dbusbuf_en = !(run_mode && !tgt_nce && (!tgt_noel || !tgt_noeh));
    assign sram_noe          = !run_mode;

    // No queue, a hit while TX FIFO is full is dropped
    assign ft240x_nwr  = !(exfil_en && !ft240x_txe && page_hit);
    assign ft240x_dout = addr_bus[7:0];
    assign ft240x_doe  = !ft240x_nwr;

    a_nwr_needs_txe : assert property (@(posedge clk24MHz) disable iff (act)
        !ft240x_nwr |-> !ft240x_txe);
    a_buf_run_only : assert property (@(posedge clk24MHz) disable iff (act)
        !target_dbusbuf_en |-> (mode == eprom_emu_pkg::mode_run));

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk24MHz,
    output logic act
);

    // 40 ns period
    initial begin
        clk24MHz = 1'b0;
        forever #20 clk24MHz = ~clk24MHz;
    end

    // Reset held over the first three rising edges
    initial begin
        act <= 1'b1;
        repeat (3) @(posedge clk24MHz);
        act <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_eprom_emu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eprom_emu;

    localparam logic kind_cmd = 1'b0;
    localparam logic kind_bus = 1'b1;

    // One step of the test holds host bytes or a target bus cycle
    typedef struct packed {
        logic        kind;
        logic [1:0]  ncmd;
        logic [7:0]  cmd0;
        logic [7:0]  cmd1;
        logic [4:0]  nwords;
        logic [17:0] addr;
        logic        nce;
        logic        noel;
        logic        noeh;
        logic        txe;
        logic        exp_run;
        logic        exp_buf_en;
        logic        exp_nwr;
    } row_t;

    logic                      clk24MHz;
    logic                      act;
    logic                      tgt_npgmh;
    logic                      tgt_npgml;
    eprom_emu_pkg::sram_addr_t addr_bus;
    logic                      tgt_nce;
    logic                      tgt_noel;
    logic                      tgt_noeh;
    logic                      target_dbusbuf_en;
    eprom_emu_pkg::usb_byte_t  ft240x_din;
    eprom_emu_pkg::usb_byte_t  ft240x_dout;
    logic                      ft240x_doe;
    logic                      ft240x_nrd;
    logic                      ft240x_nwr;
    logic                      ft240x_txe;
    logic                      ft240x_rxf;
    eprom_emu_pkg::sram_addr_t sram_addr;
    eprom_emu_pkg::sram_word_t sram_data_out;
    logic                      sram_data_oe;
    logic                      sram_nwe;
    logic                      sram_noe;

    // Host bytes, observed writes and expected writes
    eprom_emu_pkg::usb_byte_t  rx_q[$];
    eprom_emu_pkg::sram_addr_t wr_addr_q[$];
    eprom_emu_pkg::sram_word_t wr_data_q[$];
    eprom_emu_pkg::sram_addr_t exp_addr_q[$];
    eprom_emu_pkg::sram_word_t exp_data_q[$];
    eprom_emu_pkg::sram_addr_t exp_addr;
    row_t                      rows[$];
    logic [31:0]               lfsr_state = 32'h0498_ef24;
    int                        check_count = 0;
    int                        mismatch_count = 0;
    int                        cycle_count = 0;
    int                        cycle_limit = 100000;

    tb_clk_gen u_clk_gen (
        .clk24MHz (clk24MHz),
        .act      (act)
    );

    eprom_emu_top u_eprom_emu_top (
        .clk24MHz          (clk24MHz),
        .act               (act),
        .tgt_npgmh         (tgt_npgmh),
        .tgt_npgml         (tgt_npgml),
        .addr_bus          (addr_bus),
        .tgt_nce           (tgt_nce),
        .tgt_noel          (tgt_noel),
        .tgt_noeh          (tgt_noeh),
        .target_dbusbuf_en (target_dbusbuf_en),
        .ft240x_din        (ft240x_din),
        .ft240x_dout       (ft240x_dout),
        .ft240x_doe        (ft240x_doe),
        .ft240x_nrd        (ft240x_nrd),
        .ft240x_nwr        (ft240x_nwr),
        .ft240x_txe        (ft240x_txe),
        .ft240x_rxf        (ft240x_rxf),
        .sram_addr         (sram_addr),
        .sram_data_out     (sram_data_out),
        .sram_data_oe      (sram_data_oe),
        .sram_nwe          (sram_nwe),
        .sram_noe          (sram_noe)
    );

    ////////////////////////////////////////////////////////////////////////////
    // FT240X receive FIFO and SRAM models

    // Head byte shown while RD# is low, popped as RD# rises after two low cycles
    initial begin : ft240x_fifo
        logic nrd_was_low;
        nrd_was_low = 1'b0;
        ft240x_rxf <= 1'b1;
        ft240x_din <= '0;
        forever begin
            @(posedge clk24MHz);
            if (!ft240x_nrd && nrd_was_low && rx_q.size() != 0) begin
                void'(rx_q.pop_front());
            end
            nrd_was_low = !ft240x_nrd && !nrd_was_low;
            ft240x_rxf <= (rx_q.size() == 0);
            ft240x_din <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
        end
    end

    // One record per low cycle of WE#
    always @(posedge clk24MHz) begin
        if (!act && !sram_nwe) begin
            wr_addr_q.push_back(sram_addr);
            wr_data_q.push_back(sram_data_out);
        end
    end

    always @(posedge clk24MHz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout, run did not finish in %0d cycles, checks: %0d, mismatches: %0d",
                     cycle_count, check_count, mismatch_count);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per output bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic next_random_word(output logic [15:0] w);
        int b;
        w = '0;
        for (b = 0; b < 16; b++) begin
            w = {w[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    function automatic row_t cmd_row(input logic [1:0] ncmd, input logic [7:0] b0,
                                     input logic [7:0] b1, input logic [4:0] nwords);
        row_t r;
        r        = '0;
        r.kind   = kind_cmd;
        r.ncmd   = ncmd;
        r.cmd0   = b0;
        r.cmd1   = b1;
        r.nwords = nwords;
        return r;
    endfunction

    function automatic row_t bus_row(input logic [17:0] addr, input logic nce,
                                     input logic noel, input logic noeh, input logic txe,
                                     input logic run, input logic buf_en, input logic nwr);
        row_t r;
        r            = '0;
        r.kind       = kind_bus;
        r.addr       = addr;
        r.nce        = nce;
        r.noel       = noel;
        r.noeh       = noeh;
        r.txe        = txe;
        r.exp_run    = run;
        r.exp_buf_en = buf_en;
        r.exp_nwr    = nwr;
        return r;
    endfunction

    task automatic build_rows();
        rows.push_back(cmd_row(2'd1, 8'h01, 8'h00, 5'd0));
        rows.push_back(cmd_row(2'd1, 8'h23, 8'h00, 5'd3));
        // Undefined byte writes nothing and leaves LOAD in place
        rows.push_back(cmd_row(2'd1, 8'h55, 8'h00, 5'd0));
        rows.push_back(bus_row(18'h12345, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        // WRITE 0 moves 16 words
        rows.push_back(cmd_row(2'd1, 8'h20, 8'h00, 5'd16));
        // Page 0x123 then RUN without exfiltration
        rows.push_back(cmd_row(2'd2, 8'h41, 8'h23, 5'd0));
        rows.push_back(cmd_row(2'd1, 8'h11, 8'h00, 5'd0));
        rows.push_back(bus_row(18'h00010, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1));
        rows.push_back(bus_row(18'h00011, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
        rows.push_back(bus_row(18'h00012, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1));
        rows.push_back(bus_row(18'h123A5, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
        rows.push_back(bus_row(18'h3FFFF, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
        // RUN with exfiltration on
        rows.push_back(cmd_row(2'd1, 8'h15, 8'h00, 5'd0));
        rows.push_back(bus_row(18'h123A5, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
        rows.push_back(bus_row(18'h12300, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0));
        rows.push_back(bus_row(18'h123FF, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
        rows.push_back(bus_row(18'h124A5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
        rows.push_back(bus_row(18'h023A5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
        // Back to LOAD with the enable bit still set, then counter continues
        rows.push_back(cmd_row(2'd1, 8'h14, 8'h00, 5'd0));
        rows.push_back(bus_row(18'h123A5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
        rows.push_back(cmd_row(2'd1, 8'h22, 8'h00, 5'd2));
        rows.push_back(bus_row(18'h00000, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        // Counter has moved away from zero, so the clear must show on sram_addr
        rows.push_back(cmd_row(2'd1, 8'h01, 8'h00, 5'd0));
        rows.push_back(bus_row(18'h2A5A5, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        rows.push_back(cmd_row(2'd1, 8'h21, 8'h00, 5'd1));
    endtask

    task automatic compare_writes();
        eprom_emu_pkg::sram_addr_t got_addr;
        eprom_emu_pkg::sram_word_t got_data;
        check_equal("SRAM write count", 32'(wr_addr_q.size()), 32'(exp_addr_q.size()));
        while (wr_addr_q.size() != 0 && exp_addr_q.size() != 0) begin
            got_addr = wr_addr_q.pop_front();
            got_data = wr_data_q.pop_front();
            check_equal("SRAM write address", 32'(got_addr), 32'(exp_addr_q.pop_front()));
            check_equal("SRAM write data", 32'(got_data), 32'(exp_data_q.pop_front()));
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic apply_cmd(input row_t r);
        logic [15:0] w;
        int          k;
        @(negedge clk24MHz);
        rx_q.push_back(r.cmd0);
        if (r.ncmd == 2'd2) begin
            rx_q.push_back(r.cmd1);
        end
        if (r.cmd0 == 8'h01) begin
            exp_addr = '0;
        end
        // Each word goes high byte first
        for (k = 0; k < int'(r.nwords); k++) begin
            next_random_word(w);
            rx_q.push_back(w[15:8]);
            rx_q.push_back(w[7:0]);
            exp_addr_q.push_back(exp_addr);
            exp_data_q.push_back(w);
            exp_addr = exp_addr + eprom_emu_pkg::sram_addr_t'(1);
        end
        while (rx_q.size() != 0) begin
            @(negedge clk24MHz);
        end
        if (r.nwords != 5'd0) begin
            while (wr_addr_q.size() < exp_addr_q.size()) begin
                @(negedge clk24MHz);
            end
            // Release and increment cycles of the last word
            repeat (2) @(negedge clk24MHz);
        end else begin
            repeat (4) @(negedge clk24MHz);
        end
        compare_writes();
    endtask

    task automatic apply_bus(input row_t r);
        @(posedge clk24MHz);
        addr_bus   <= r.addr;
        tgt_nce    <= r.nce;
        tgt_noel   <= r.noel;
        tgt_noeh   <= r.noeh;
        ft240x_txe <= r.txe;
        @(negedge clk24MHz);
        check_equal("target_dbusbuf_en", 32'(target_dbusbuf_en), 32'(r.exp_buf_en));
        check_equal("sram_noe", 32'(sram_noe), 32'(!r.exp_run));
        check_equal("sram_data_oe", 32'(sram_data_oe), 32'(!r.exp_run));
        check_equal("sram_addr", 32'(sram_addr), r.exp_run ? 32'(r.addr) : 32'(exp_addr));
        check_equal("sram_nwe", 32'(sram_nwe), 32'd1);
        check_equal("ft240x_nwr", 32'(ft240x_nwr), 32'(r.exp_nwr));
        check_equal("ft240x_doe", 32'(ft240x_doe), 32'(!r.exp_nwr));
        if (!r.exp_nwr) begin
            check_equal("ft240x_dout", 32'(ft240x_dout), 32'(r.addr[7:0]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : stimulus
        int i;
        tgt_npgmh  <= 1'b1;
        tgt_npgml  <= 1'b1;
        addr_bus   <= '0;
        tgt_nce    <= 1'b1;
        tgt_noel   <= 1'b1;
        tgt_noeh   <= 1'b1;
        ft240x_txe <= 1'b0;
        exp_addr = '0;
        build_rows();
        // About 40 cycles per word plus the command bytes
        cycle_limit = 40;
        foreach (rows[j]) begin
            cycle_limit += 30 + 40 * int'(rows[j].nwords);
        end
        cycle_limit += 200;

        @(negedge act);
        // Idle strobes after reset
        repeat (3) begin
            @(negedge clk24MHz);
            check_equal("ft240x_nrd after reset", 32'(ft240x_nrd), 32'd1);
            check_equal("ft240x_nwr after reset", 32'(ft240x_nwr), 32'd1);
            check_equal("sram_nwe after reset", 32'(sram_nwe), 32'd1);
            check_equal("sram_noe after reset", 32'(sram_noe), 32'd1);
            check_equal("target_dbusbuf_en after reset", 32'(target_dbusbuf_en), 32'd1);
            check_equal("sram_data_oe after reset", 32'(sram_data_oe), 32'd1);
            check_equal("sram_addr after reset", 32'(sram_addr), 32'd0);
        end

        for (i = 0; i < rows.size(); i++) begin
            if (rows[i].kind == kind_bus) begin
                apply_bus(rows[i]);
            end else begin
                apply_cmd(rows[i]);
            end
        end

        $display("Checks: %0d, mismatches: %0d", check_count, mismatch_count);
        if (mismatch_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
